// ==== files.f ====
sigdel_pkg.sv
clkdiv.sv
sdm_mod.sv
sinc_filter.sv
pwm.sv
sigdel.sv
sigdel_check.sv
tb_sigdel.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sigma-delta testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_sigdel -o sim_sigdel &&
./obj_dir/sim_sigdel | tee /dev/stderr | grep -q "all tests passed" &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }

// ==== tb_sigdel.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sigdel;

  import sigdel_pkg::*;

  localparam int clk_period   = 100;
  localparam int drive_dly    = 10;                  // After rising edge
  localparam int rst_cycles   = 5;
  localparam int n_seg        = 16;
  localparam int seg_clks     = 4096;                // 64 decimations per code
  localparam int timeout_clks = n_seg * seg_clks + 200;

  localparam logic [31:0] lfsr_seed = 32'h7e72;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

  logic              clk;
  logic              rst_n;
  logic [code_w-1:0] code;
  sinc_res_t         res;
  logic              pwm_out;
  int                errors;
  int                checks;
  logic [31:0]       lfsr;

  // One Galois step, taps folded in on a set low bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? lfsr_taps : 32'h0);
  endfunction

  // Eight steps, one per code bit
  task automatic draw_code(output logic [code_w-1:0] c);
    c = '0;
    for (int b = 0; b < code_w; b++) begin
      c    = {c[code_w-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  //////////////////////////////
  // DUT and checker
  //////////////////////////////
  sigdel dut_i (
    .clk(clk), .rst_n(rst_n), .code(code), .res(res), .pwm_out(pwm_out)
  );

  sigdel_check chk_i (
    .clk(clk), .rst_n(rst_n), .code(code), .res(res), .pwm_out(pwm_out),
    .errors(errors), .checks(checks)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Whole run plus some margin
  initial begin
    #(timeout_clks * clk_period);
    $display("timeout: run did not finish after %0d clocks", timeout_clks);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    rst_n = 1'b0;
    code  = '0;
    lfsr  = lfsr_seed;
    repeat (rst_cycles) @(posedge clk);
    #(drive_dly);
    rst_n = 1'b1;
    for (int seg = 0; seg < n_seg; seg++) begin
      if (seg == 0) begin
        code = '0;           // Empty stream
      end else if (seg == 1) begin
        code = '1;           // Near full scale
      end else begin
        draw_code(code);
      end
      $display("segment %0d, code %h", seg, code);
      repeat (seg_clks) @(posedge clk);
      #(drive_dly);
    end
    @(posedge clk);  // Last valid of the run still to be compared
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sigdel_check.sv ====
`timescale 1ns/1ns
`default_nettype none

module sigdel_check (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [sigdel_pkg::code_w-1:0] code,
  input  sigdel_pkg::sinc_res_t         res,
  input  logic                          pwm_out,
  output int                            errors,
  output int                            checks
);

  import sigdel_pkg::*;

  int err_cnt = 0;
  int chk_cnt = 0;

  assign errors = err_cnt;
  assign checks = chk_cnt;

  //////////////////////////////
  // Chain model state
  //////////////////////////////
  logic [cnt_w-1:0]  m_cnt;             // Own copy of the divider count
  logic [code_w-1:0] m_acc;             // Modulator residue
  logic              m_bit;             // Registered stream bit
  logic [acc_w-1:0]  m_int [3][3];      // Integrators per order
  logic [acc_w-1:0]  m_dly [3][3];      // Comb delays per order
  logic [acc_w-1:0]  m_res [3];         // Decimated words
  logic              m_valid;
  logic [osr-1:0]    m_hist;            // Last osr samples, newest in bit 0
  logic [acc_w-1:0]  m_ones;            // Ones among them at last decimation
  logic [code_w-1:0] m_pcnt;            // PWM counter
  logic [code_w-1:0] m_wq;              // Latched PWM width
  logic              m_pwm;
  logic [code_w-1:0] m_last_code;       // Code now in force
  int                m_settle;          // Decimations since code change
  int                rel_clk;           // Rising edges since reset release
  logic              live = 1'b0;       // Set once reset has been seen

  // Width rule: s3 / 16, clipped to 255 from 4096 up
  function automatic logic [code_w-1:0] saturate_width(input logic [acc_w-1:0] s);
    if (s >= 16'd4096) begin
      return 8'hff;
    end
    return 8'(s / 16'd16);
  endfunction

  task automatic compare_word(input string name, input logic [acc_w-1:0] dut,
                              input logic [acc_w-1:0] exp);
    chk_cnt++;
    if (dut !== exp) begin
      err_cnt++;
      $display("error %s: dut %h, model %h, clock %0d", name, dut, exp, rel_clk);
    end
  endtask

  task automatic compare_level(input string name, input logic dut, input logic exp);
    chk_cnt++;
    if (dut !== exp) begin
      err_cnt++;
      $display("error %s: dut %h, model %h, clock %0d", name, dut, exp, rel_clk);
    end
  endtask

  // Settled sinc3 near code * 16^3 / 256, band of 16 * 16
  task automatic check_settled();
    int target;
    int diff;
    target = 16 * int'(m_last_code);
    diff   = int'(res.s3) - target;
    if (diff < 0) diff = -diff;
    chk_cnt++;
    if (diff > 256 || (m_last_code == 8'h00 && res.s3 != 16'h0000) ||
        (m_last_code == 8'hff && res.s3 > 16'd4096)) begin
      err_cnt++;
      $display("error res.s3 settled: dut %h, expected %h within %h, code %h",
               res.s3, 16'(target), 16'd256, m_last_code);
    end
  endtask

  //////////////////////////////
  // Model, stepped on rising edge
  //////////////////////////////
  always @(posedge clk) begin : model
    logic             fs;
    logic             dec;
    logic [code_w:0]  sum;
    logic [acc_w-1:0] x;
    logic [acc_w-1:0] y;
    if (!rst_n) begin
      m_cnt   = '0;
      m_acc   = '0;
      m_bit   = 1'b0;
      for (int o = 0; o < 3; o++) begin
        for (int i = 0; i < 3; i++) begin
          m_int[o][i] = '0;
          m_dly[o][i] = '0;
        end
        m_res[o] = '0;
      end
      m_valid     = 1'b0;
      m_hist      = '0;
      m_ones      = '0;
      m_pcnt      = '0;
      m_wq        = '0;
      m_pwm       = 1'b0;
      m_last_code = code;
      m_settle    = 0;
      rel_clk     = 0;
      live        = 1'b1;
    end else begin
      fs  = (int'(m_cnt) % fs_div) == fs_div - 1;   // Every 4th clock
      dec = int'(m_cnt) == dec_div - 1;             // Every 64th, with fs
      if (code != m_last_code) begin
        m_last_code = code;
        m_settle    = 0;
      end
      if (m_valid) m_wq = saturate_width(m_res[2]);  // Load on clock after valid
      m_pcnt  = m_pcnt + 8'd1;
      m_valid = dec;
      if (fs) begin
        m_hist = {m_hist[osr-2:0], m_bit};
        for (int o = 0; o < 3; o++) begin
          m_int[o][0] = m_int[o][0] + {{(acc_w-1){1'b0}}, m_bit};
          for (int i = 1; i <= o; i++) begin
            m_int[o][i] = m_int[o][i] + m_int[o][i-1];  // Newest lower stage
          end
        end
        if (dec) begin
          for (int o = 0; o < 3; o++) begin
            x = m_int[o][o];
            for (int i = 0; i <= o; i++) begin
              y           = x - m_dly[o][i];
              m_dly[o][i] = x;
              x           = y;
            end
            m_res[o] = x;
          end
          m_ones = 16'($countones(m_hist));
          m_settle++;
        end
        // Carry of the code add is the next bit
        sum   = {1'b0, m_acc} + {1'b0, code};
        m_acc = sum[code_w-1:0];
        m_bit = sum[code_w];
      end
      m_pwm   = m_pcnt < m_wq;
      m_cnt   = m_cnt + 1'b1;
      rel_clk++;
    end
  end

  //////////////////////////////
  // Compare mid cycle
  //////////////////////////////
  always @(negedge clk) begin
    if (live) begin
      compare_word("res.s1", res.s1, m_res[0]);
      compare_word("res.s1 ones count", res.s1, m_ones);  // Sinc1 is a plain count
      compare_word("res.s2", res.s2, m_res[1]);
      compare_word("res.s3", res.s3, m_res[2]);
      compare_level("res.valid", res.valid, m_valid);
      compare_level("pwm_out", pwm_out, m_pwm);
      // High after edge 64, 128 and so on
      if (res.valid !== ((rel_clk > 0) && (rel_clk % dec_div == 0))) begin
        err_cnt++;
        $display("valid pulse is off the 64-clock grid at clock %0d", rel_clk);
      end
      if (res.valid === 1'b1 && m_settle >= 3) check_settled();
    end
  end

endmodule

`default_nettype wire

// ==== sigdel.sv ====
`timescale 1ns/1ns
`default_nettype none

module sigdel (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [sigdel_pkg::code_w-1:0] code,
  output sigdel_pkg::sinc_res_t         res,
  output logic                          pwm_out
);

  import sigdel_pkg::*;

  logic fs_en;      // Sample strobe
  logic dec_en;     // Decimation strobe
  logic bitstream;  // Modulator output

  logic [acc_w-1:0] s1;
  logic [acc_w-1:0] s2;
  logic [acc_w-1:0] s3;
  logic             v3;

  logic [code_w-1:0] pwm_width;

  //////////////////////////////
  // Strobes and modulator
  //////////////////////////////
  clkdiv u_clkdiv (.clk(clk), .rst_n(rst_n), .fs_en(fs_en), .dec_en(dec_en));

  sdm_mod u_sdm (
    .clk(clk), .rst_n(rst_n), .fs_en(fs_en), .code(code), .bitstream(bitstream)
  );

  //////////////////////////////
  // Decimators, same stream
  //////////////////////////////
  sinc_filter #(.order(1)) u_sinc1 (
    .clk(clk), .rst_n(rst_n), .fs_en(fs_en), .dec_en(dec_en),
    .bitstream(bitstream), .result(s1), .valid()
  );

  sinc_filter #(.order(2)) u_sinc2 (
    .clk(clk), .rst_n(rst_n), .fs_en(fs_en), .dec_en(dec_en),
    .bitstream(bitstream), .result(s2), .valid()
  );

  sinc_filter #(.order(3)) u_sinc3 (
    .clk(clk), .rst_n(rst_n), .fs_en(fs_en), .dec_en(dec_en),
    .bitstream(bitstream), .result(s3), .valid(v3)
  );

  assign res = '{s1: s1, s2: s2, s3: s3, valid: v3};  // Sinc3 valid stands for all

  // Sinc3 bits 11..4, clipped at 4096 and above
  assign pwm_width = (|s3[acc_w-1:pwm_lsb+code_w]) ? '1 : s3[pwm_lsb +: code_w];

  pwm u_pwm (
    .clk(clk), .rst_n(rst_n), .load(v3), .width(pwm_width), .pwm_out(pwm_out)
  );

endmodule

`default_nettype wire

// ==== pwm.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load,
  input  logic [sigdel_pkg::code_w-1:0] width,
  output logic                          pwm_out
);

  import sigdel_pkg::*;

  logic [code_w-1:0] cnt;       // Period of 256 clocks
  logic [code_w-1:0] width_q;   // Latched duty

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // New width taken on the clock after load
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      width_q <= '0;
    end else if (load) begin
      width_q <= width;
    end
  end

  // High for width_q clocks per period
  // Width zero never goes high
  assign pwm_out = (cnt < width_q);

endmodule

`default_nettype wire

// ==== sinc_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module sinc_filter #(
  parameter int order = 3   // CIC order, 1 to 3
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         fs_en,
  input  logic                         dec_en,
  input  logic                         bitstream,
  output logic [sigdel_pkg::acc_w-1:0] result,
  output logic                         valid
);

  import sigdel_pkg::*;

  if (order < 1 || order > 3) begin : g_order_chk
    $error("sinc_filter: order %0d outside 1 to 3", order);
  end

  //////////////////////////////
  // Integrators at sample rate
  //////////////////////////////
  logic [acc_w-1:0] integ     [order];  // Integrator state
  logic [acc_w-1:0] integ_nxt [order];  // Value after this sample

  always_comb begin
    // Bitstream counts as 0 or 1
    integ_nxt[0] = integ[0] + {{(acc_w-1){1'b0}}, bitstream};
    for (int i = 1; i < order; i++) begin
      integ_nxt[i] = integ[i] + integ_nxt[i-1];  // Chain on new value
    end
  end

  //////////////////////////////
  // Combs at decimated rate
  //////////////////////////////
  logic [acc_w-1:0] comb_in  [order];
  logic [acc_w-1:0] comb_out [order];
  logic [acc_w-1:0] comb_dly [order];   // Input at previous dec_en

  always_comb begin
    comb_in[0]  = integ_nxt[order-1];
    comb_out[0] = comb_in[0] - comb_dly[0];
    for (int j = 1; j < order; j++) begin
      comb_in[j]  = comb_out[j-1];
      comb_out[j] = comb_in[j] - comb_dly[j];   // Wraps mod 2^16
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < order; k++) begin
        integ[k]    <= '0;
        comb_dly[k] <= '0;
      end
      result <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= dec_en;  // Single pulse, one clock late
      if (fs_en) begin
        for (int k = 0; k < order; k++) begin
          integ[k] <= integ_nxt[k];
        end
      end
      if (dec_en) begin
        for (int k = 0; k < order; k++) begin
          comb_dly[k] <= comb_in[k];
        end
        result <= comb_out[order-1];  // Held until next decimation
      end
    end
  end

  // Result word only announced right after a decimation strobe
  a_valid_after_dec : assert property (
    @(posedge clk) disable iff (!rst_n) valid |-> $past(dec_en)
  ) else $error("sinc_filter: valid without preceding dec_en");

endmodule

`default_nettype wire

// ==== sdm_mod.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdm_mod (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fs_en,
  input  logic [sigdel_pkg::code_w-1:0] code,
  output logic                          bitstream
);

  import sigdel_pkg::*;

  // First order error feedback loop
  // Residue stays in acc, overflow is the output bit
  logic [code_w-1:0] acc;
  logic [code_w:0]   sum;   // Carry in top bit

  assign sum = {1'b0, acc} + {1'b0, code};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc       <= '0;
      bitstream <= 1'b0;
    end else if (fs_en) begin
      acc       <= sum[code_w-1:0];   // Keep quantization error
      bitstream <= sum[code_w];       // Density code/256
    end
  end
  // Bitstream held between strobes

endmodule

`default_nettype wire

// ==== clkdiv.sv ====
`timescale 1ns/1ns
`default_nettype none

module clkdiv (
  input  logic clk,
  input  logic rst_n,
  output logic fs_en,
  output logic dec_en
);

  import sigdel_pkg::*;

  logic [cnt_w-1:0] cnt;  // Free running, wraps every dec_div clocks

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Sample strobe when low bits all ones
  assign fs_en  = &cnt[fs_w-1:0];
  assign dec_en = &cnt;           // Last clock of the 64-clock frame

  //////////////////////////////
  // Checks
  //////////////////////////////
  // Filters run combs only on dec_en and need a fresh sample there too
  a_dec_on_fs : assert property (
    @(posedge clk) disable iff (!rst_n) dec_en |-> fs_en
  ) else $error("clkdiv: dec_en without fs_en");

endmodule

`default_nettype wire

// ==== sigdel_pkg.sv ====
`default_nettype none

package sigdel_pkg;

  //////////////////////////////
  // Strobe rates
  //////////////////////////////
  localparam int fs_div  = 4;               // Clocks per sample strobe
  localparam int osr     = 16;              // Oversampling ratio
  localparam int dec_div = fs_div * osr;    // Clocks per decimated word

  localparam int cnt_w = $clog2(dec_div);   // Divider counter, 6 bits
  localparam int fs_w  = $clog2(fs_div);    // Low bits that make fs_en

  //////////////////////////////
  // Word widths
  //////////////////////////////
  localparam int acc_w  = 16;   // Integrator, comb and result words
  localparam int code_w = 8;    // Modulator code and PWM width

  // Sinc3 bits 11..4 feed the PWM
  localparam int pwm_lsb = 4;

  // Results of all three decimators, one word per decimation
  typedef struct packed {
    logic [acc_w-1:0] s1;     // Sinc1, ones in last osr samples
    logic [acc_w-1:0] s2;     // Sinc2
    logic [acc_w-1:0] s3;     // Sinc3
    logic             valid;  // One clock after dec_en
  } sinc_res_t;

endpackage

`default_nettype wire
